/* design/items_vld_cfg.svh */
/*
 * Width and size constants of the item valid extraction block
 */

`ifndef ITEMS_VLD_CFG_SVH
`define ITEMS_VLD_CFG_SVH

// Word geometry
`define ITEMS        4
`define ITEM_WIDTH   8

// Largest packet, in items
`define PKT_MTU      256

// Metadata and position fields
`define OFFSET_WIDTH 8
`define LENGTH_WIDTH 9
`define POS_WIDTH    9

`endif

/* design/items_vld_pkg.sv */
/*
 * Vector typedefs, RX/TX word structs and tracker state enum
 */

`default_nettype none

`include "items_vld_cfg.svh"

package items_vld_pkg;

    typedef logic [`ITEM_WIDTH-1:0]      item_t;
    typedef item_t [`ITEMS-1:0]          data_t;
    typedef logic [`ITEMS-1:0]           item_mask_t;
    typedef logic [$clog2(`ITEMS)-1:0]   item_idx_t;
    typedef logic [`OFFSET_WIDTH-1:0]    offset_t;
    typedef logic [`LENGTH_WIDTH-1:0]    length_t;
    typedef logic [`POS_WIDTH-1:0]       pos_t;

    // Per-packet window, valid on SOF
    typedef struct packed {
        logic    enable;
        length_t length;
        offset_t offset;
    } rx_meta_t;

    typedef struct packed {
        data_t     data;
        logic      sof;
        logic      eof;
        item_idx_t eof_pos;   // Last item of the packet
        rx_meta_t  meta;
    } rx_word_t;

    typedef struct packed {
        data_t      data;
        item_mask_t vld;
    } tx_word_t;

    typedef enum logic {idle, in_packet} pkt_state_e;

endpackage

`default_nettype wire

/* design/pkt_position_tracker.sv */
/*
 * Packet position tracker
 * Word counter and metadata latch, held from SOF to EOF
 */

`timescale 1ns/1ns
`default_nettype none

`include "items_vld_cfg.svh"

module pkt_position_tracker (
    input  logic                    clk,
    input  logic                    reset,
    input  items_vld_pkg::rx_word_t rx_word,
    input  logic                    accept,
    output items_vld_pkg::pos_t     pkt_pos,
    output items_vld_pkg::rx_meta_t cur_meta
);

    import items_vld_pkg::*;

    localparam int IDX_WIDTH  = $bits(item_idx_t);
    localparam int WCNT_WIDTH = $clog2(`PKT_MTU / `ITEMS);

    pkt_state_e            state;
    logic [WCNT_WIDTH-1:0] word_cnt;   // Index of the next word in the packet
    rx_meta_t              meta_q;

    // ========================================
    // State, counter and metadata latch
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            word_cnt <= '0;
            meta_q   <= '0;
        end else if (accept) begin
            if (rx_word.sof) begin
                meta_q   <= rx_word.meta;
                word_cnt <= WCNT_WIDTH'(1);
                state    <= rx_word.eof ? idle : in_packet;
            end else if (state == in_packet) begin
                word_cnt <= word_cnt + WCNT_WIDTH'(1);
                if (rx_word.eof)
                    state <= idle;
            end
        end
    end

    // ========================================
    // Outputs for the current word
    // ========================================
    always_comb begin
        if (rx_word.sof) begin
            pkt_pos  = '0;
            cur_meta = rx_word.meta;   // Live on SOF
        end else begin
            pkt_pos  = pos_t'({word_cnt, {IDX_WIDTH{1'b0}}});
            cur_meta = meta_q;
        end
    end

endmodule

`default_nettype wire

/* design/item_valid_mask.sv */
/*
 * Per-item valid mask of one word
 * Window check against offset/length, cut at EOF
 */

`timescale 1ns/1ns
`default_nettype none

`include "items_vld_cfg.svh"

module item_valid_mask (
    input  items_vld_pkg::rx_word_t rx_word,
    input  items_vld_pkg::pos_t     pkt_pos,
    input  items_vld_pkg::rx_meta_t cur_meta,
    output items_vld_pkg::tx_word_t out_word
);

    import items_vld_pkg::*;

    // One extra bit so offset plus length cannot wrap
    localparam int CMP_WIDTH = `LENGTH_WIDTH + 1;

    logic [CMP_WIDTH-1:0] win_lo;
    logic [CMP_WIDTH-1:0] win_hi;

    assign win_lo = CMP_WIDTH'(cur_meta.offset);
    assign win_hi = CMP_WIDTH'(cur_meta.offset) + CMP_WIDTH'(cur_meta.length);

    // ========================================
    // Mask per item
    // ========================================
    always_comb begin
        logic [CMP_WIDTH-1:0] item_pos;
        logic                 in_pkt;

        out_word.data = rx_word.data;   // Data unchanged
        for (int i = 0; i < `ITEMS; i++) begin
            item_pos = CMP_WIDTH'(pkt_pos) + CMP_WIDTH'(i);
            in_pkt   = !rx_word.eof || (item_idx_t'(i) <= rx_word.eof_pos);

            out_word.vld[i] = cur_meta.enable
                           && (item_pos >= win_lo)
                           && (item_pos < win_hi)
                           && in_pkt;
        end
    end

endmodule

`default_nettype wire

/* design/tx_word_buffer.sv */
/*
 * Two-entry output buffer
 * Drops words with an empty mask, back-pressures when full
 */

`timescale 1ns/1ns
`default_nettype none

module tx_word_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  items_vld_pkg::tx_word_t in_word,
    input  logic                    in_src_rdy,
    output logic                    in_dst_rdy,
    output items_vld_pkg::tx_word_t tx_word,
    output logic                    tx_src_rdy,
    input  logic                    tx_dst_rdy
);

    import items_vld_pkg::*;

    tx_word_t   head_q;   // Presented on TX
    tx_word_t   tail_q;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_dst_rdy = (count != 2'd2);
    assign tx_src_rdy = (count != 2'd0);
    assign tx_word    = head_q;

    // Empty words are taken but not stored
    assign push = in_src_rdy && in_dst_rdy && (|in_word.vld);
    assign pop  = tx_src_rdy && tx_dst_rdy;

    // ========================================
    // Fill count
    // ========================================
    always_ff @(posedge clk) begin
        if (reset)
            count <= 2'd0;
        else if (push && !pop)
            count <= count + 2'd1;
        else if (pop && !push)
            count <= count - 2'd1;
    end

    // Entry data
    always_ff @(posedge clk) begin
        case ({push, pop})
            2'b10: begin
                if (count == 2'd0)
                    head_q <= in_word;
                else
                    tail_q <= in_word;
            end
            2'b01: head_q <= tail_q;   // Shift up
            2'b11: head_q <= in_word;  // Only with one entry held
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/items_vld_top.sv */
/*
 * Item valid extraction top level
 * Position tracker, per-item mask stage and output buffer
 */

`timescale 1ns/1ns
`default_nettype none

module items_vld_top (
    input  logic                    clk,
    input  logic                    reset,
    input  items_vld_pkg::rx_word_t rx_word,
    input  logic                    rx_src_rdy,
    output logic                    rx_dst_rdy,
    output items_vld_pkg::tx_word_t tx_word,
    output logic                    tx_src_rdy,
    input  logic                    tx_dst_rdy
);

    import items_vld_pkg::*;

    logic     accept;
    pos_t     pkt_pos;
    rx_meta_t cur_meta;
    tx_word_t mask_word;

    assign accept = rx_src_rdy && rx_dst_rdy;   // RX transfer

    pkt_position_tracker u_tracker (
        .clk      (clk),
        .reset    (reset),
        .rx_word  (rx_word),
        .accept   (accept),
        .pkt_pos  (pkt_pos),
        .cur_meta (cur_meta)
    );

    item_valid_mask u_mask (
        .rx_word  (rx_word),
        .pkt_pos  (pkt_pos),
        .cur_meta (cur_meta),
        .out_word (mask_word)
    );

    tx_word_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .in_word    (mask_word),
        .in_src_rdy (rx_src_rdy),
        .in_dst_rdy (rx_dst_rdy),
        .tx_word    (tx_word),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

endmodule

`default_nettype wire

/* dv/items_vld_chk.sv */
/*
 * Bound assertions on the TX side of the item valid top level
 * Stall stability, reset state, no empty transfers
 */

`timescale 1ns/1ns
`default_nettype none

module items_vld_chk (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire items_vld_pkg::tx_word_t tx_word,
    input wire logic                    tx_src_rdy,
    input wire logic                    tx_dst_rdy
);

    import items_vld_pkg::*;

    int unsigned fail_count = 0;   // Failed assertions so far

    // Held word stays put until taken
    a_tx_stable : assert property (@(posedge clk) disable iff (reset)
        tx_src_rdy && !tx_dst_rdy |=> tx_src_rdy && $stable(tx_word))
        else begin
            $error("tx_word changed while stalled");
            fail_count++;
        end

    a_reset_idle : assert property (@(posedge clk)
        reset |=> !tx_src_rdy)
        else begin
            $error("tx_src_rdy high after reset");
            fail_count++;
        end

    // Empty words never leave the buffer
    a_no_empty : assert property (@(posedge clk) disable iff (reset)
        tx_src_rdy && tx_dst_rdy |-> |tx_word.vld)
        else begin
            $error("transferred tx_word has an empty mask");
            fail_count++;
        end

endmodule

bind items_vld_top items_vld_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .tx_word    (tx_word),
    .tx_src_rdy (tx_src_rdy),
    .tx_dst_rdy (tx_dst_rdy)
);

`default_nettype wire

/* dv/items_vld_tb.sv */
/*
 * Testbench for the item valid extraction top level
 * Packet table, reference mask model, random TX stalls
 */

`timescale 1ns/1ns
`default_nettype none

`include "items_vld_cfg.svh"

module items_vld_tb;

    import items_vld_pkg::*;

    typedef struct packed {
        logic [8:0] pkt_len;   // Packet size in items
        offset_t    offset;
        length_t    length;
        logic       enable;
        logic       gap;       // Idle cycle before each word
    } pkt_row_t;

    localparam int TIMEOUT = 200;

    logic     clk;
    logic     reset;
    rx_word_t rx_word;
    logic     rx_src_rdy;
    logic     rx_dst_rdy;
    tx_word_t tx_word;
    logic     tx_src_rdy;
    logic     tx_dst_rdy;

    integer   seed = 32'hea88;
    pkt_row_t pkt_table[$];
    tx_word_t exp_q[$];
    tx_word_t mon_word;
    int       item_cnt;

    items_vld_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .rx_word    (rx_word),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_word    (tx_word),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    always #5 clk = ~clk;

    // Random TX back-pressure
    always @(posedge clk)
        tx_dst_rdy <= !reset && (($random(seed) & 3) != 0);

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s actual %0h expected %0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic add_row(input int pkt_len, input int offset, input int length,
                           input bit enable, input bit gap);
        pkt_row_t row;
        row.pkt_len = 9'(pkt_len);
        row.offset  = offset_t'(offset);
        row.length  = length_t'(length);
        row.enable  = enable;
        row.gap     = gap;
        pkt_table.push_back(row);
    endtask

    // Window rule for one word of a packet
    function automatic item_mask_t expected_mask(input pkt_row_t row, input int word_idx);
        item_mask_t mask;
        int         pos;
        for (int i = 0; i < `ITEMS; i++) begin
            pos     = word_idx * `ITEMS + i;
            mask[i] = row.enable
                   && (pos >= int'(row.offset))
                   && (pos < int'(row.offset) + int'(row.length))
                   && (pos < int'(row.pkt_len));
        end
        return mask;
    endfunction

    task automatic send_word(input rx_word_t word);
        int waited;
        waited     = 0;
        rx_word    <= word;
        rx_src_rdy <= 1'b1;
        @(negedge clk);
        while (!rx_dst_rdy) begin
            waited++;
            if (waited > TIMEOUT)
                report_failure("RX word was never accepted");
            @(negedge clk);
        end
        @(posedge clk);   // Transfer edge
    endtask

    task automatic send_packet(input pkt_row_t row);
        rx_word_t word;
        tx_word_t exp_word;
        int       n_words;
        n_words = (int'(row.pkt_len) + `ITEMS - 1) / `ITEMS;
        for (int k = 0; k < n_words; k++) begin
            for (int i = 0; i < `ITEMS; i++) begin
                word.data[i] = item_t'(item_cnt);
                item_cnt++;
            end
            word.sof         = (k == 0);
            word.eof         = (k == n_words - 1);
            word.eof_pos     = word.eof ? item_idx_t'((int'(row.pkt_len) - 1) % `ITEMS) : '0;
            word.meta.enable = row.enable;
            word.meta.length = row.length;
            word.meta.offset = row.offset;
            if (!word.sof)
                word.meta = ~word.meta;   // Must be ignored after SOF
            exp_word.data = word.data;
            exp_word.vld  = expected_mask(row, k);
            if (exp_word.vld != '0)
                exp_q.push_back(exp_word);
            if (row.gap) begin
                rx_src_rdy <= 1'b0;
                @(posedge clk);
            end
            send_word(word);
        end
    endtask

    // ========================================
    // TX monitor
    // ========================================
    always @(negedge clk) begin
        if (!reset && tx_src_rdy && tx_dst_rdy) begin
            if (exp_q.size() == 0) begin
                report_failure("TX word arrived with no word expected");
            end else begin
                mon_word = exp_q.pop_front();
                compare_value("tx_word.data", 64'(tx_word.data), 64'(mon_word.data));
                compare_value("tx_word.vld", 64'(tx_word.vld), 64'(mon_word.vld));
            end
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_chk.fail_count != 0)
            report_failure("an assertion on the TX side failed");
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        int waited;
        clk        = 1'b0;
        reset      = 1'b1;
        rx_word    = '0;
        rx_src_rdy = 1'b0;
        tx_dst_rdy = 1'b0;
        item_cnt   = 0;

        // pkt_len, offset, length, enable, gap
        add_row(16,   3,   6, 1'b1, 1'b0);   // Window inside the packet
        add_row(10,   6,  20, 1'b1, 1'b0);   // Cut at EOF
        add_row(12,   0,  12, 1'b0, 1'b0);   // Disabled
        add_row(3,    1,   2, 1'b1, 1'b0);   // Single words back to back
        add_row(4,    0,   4, 1'b1, 1'b0);
        add_row(1,    0,   1, 1'b1, 1'b0);
        add_row(20,   5,   9, 1'b1, 1'b1);
        add_row(37,   2,  40, 1'b1, 1'b1);
        add_row(64,  17,  30, 1'b1, 1'b0);
        add_row(256, 250, 100, 1'b1, 1'b0);  // Largest packet
        add_row(9,   12,   3, 1'b1, 1'b1);   // Window past the packet

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        foreach (pkt_table[p])
            send_packet(pkt_table[p]);
        rx_src_rdy <= 1'b0;

        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT * 10)
                report_failure("expected output never arrived");
        end
        repeat (10) @(posedge clk);   // Room for stray words

        if (u_dut.u_chk.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("an assertion on the TX side failed");
        end
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
design/items_vld_pkg.sv
design/pkt_position_tracker.sv
design/item_valid_mask.sv
design/tx_word_buffer.sv
design/items_vld_top.sv
dv/items_vld_chk.sv
dv/items_vld_tb.sv

/* Bender.yml */
package:
  name: items_vld

sources:
  - include_dirs:
      - design
    files:
      - design/items_vld_pkg.sv
      - design/pkt_position_tracker.sv
      - design/item_valid_mask.sv
      - design/tx_word_buffer.sv
      - design/items_vld_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - dv/items_vld_chk.sv
      - dv/items_vld_tb.sv
